// File: Makefile
# Verilator build and run for the cpu host memory testbench

VERILATOR ?= verilator
TOP       ?= tb_cpu_host_mem
BUILD_DIR ?= obj_dir
FILELIST  ?= all.f
VFLAGS    ?= --binary --timing

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

# rebuilt only when a source or the file list changes
$(SIM): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "TESTS PASSED"

clean:
	rm -rf $(BUILD_DIR)

// File: all.f
hdl/cpu_host_pkg.sv
hdl/word_mem.sv
hdl/boot_loader.sv
hdl/host_writer.sv
hdl/cpu_host_mem.sv
tb/host_model.sv
tb/tb_cpu_host_mem.sv

// File: hdl/boot_loader.sv
// boot loader: fetches data and instruction blocks from the host, then runs
`timescale 1ns/1ps
`default_nettype none

module boot_loader (
    input  wire                         clk,
    input  wire                         rst_n,
    input  wire                         ready,
    input  wire                         rd_valid,
    input  wire                         tx_done,
    input  wire [31:0]                  ex_wrt_data,
    input  wire cpu_host_pkg::mem_wr_t  store,
    output cpu_host_pkg::host_req_t     boot_req,
    output cpu_host_pkg::mem_wr_t       dm_wr,
    output cpu_host_pkg::mem_wr_t       im_wr,
    output cpu_host_pkg::mem_wr_t       run_store,
    output logic                        running
);

    import cpu_host_pkg::*;

    typedef enum logic [2:0] {
        IDLE,
        WAIT_DM,
        LOAD_DM,
        WAIT_IM,
        LOAD_IM,
        RUN
    } state_e;

    state_e state;
    state_e next_state;

    logic [DM_CNT_W-1:0] dm_cnt;
    logic [IM_CNT_W-1:0] im_cnt;
    logic [15:0]         word_addr;             // next word to write in a burst

    logic        in_im;                          // instruction side of boot
    logic [15:0] blk_base;
    logic        set_addr;
    logic        inc_addr;
    logic        dm_step;
    logic        im_step;
    logic        dm_last;
    logic        im_last;
    mem_wr_t     boot_wr;

    ////////////////////////////////////////
    // block tables
    ////////////////////////////////////////

    assign in_im    = (state == WAIT_IM) || (state == LOAD_IM);
    assign blk_base = in_im ? IM_BASES[im_cnt] : DM_BASES[dm_cnt];
    assign dm_last  = (dm_cnt == DM_CNT_W'(DM_BLOCKS - 1));
    assign im_last  = (im_cnt == IM_CNT_W'(IM_BLOCKS - 1));

    // first word lands on the base, the rest follow the address register
    assign boot_wr.addr = set_addr ? blk_base : word_addr;
    assign boot_wr.data = ex_wrt_data;
    assign boot_wr.en   = set_addr || inc_addr;

    ////////////////////////////////////////
    // state machine
    ////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        set_addr   = 1'b0;
        inc_addr   = 1'b0;
        dm_step    = 1'b0;
        im_step    = 1'b0;

        case (state)
            IDLE: begin
                if (ready) next_state = WAIT_DM;
            end
            WAIT_DM: begin
                if (rd_valid) begin
                    set_addr   = 1'b1;
                    next_state = LOAD_DM;
                end
            end
            LOAD_DM: begin
                inc_addr = 1'b1;            // tx_done word is written too
                if (tx_done) begin
                    if (dm_last) begin
                        next_state = WAIT_IM;
                    end else begin
                        dm_step    = 1'b1;
                        next_state = WAIT_DM;
                    end
                end
            end
            WAIT_IM: begin
                if (rd_valid) begin
                    set_addr   = 1'b1;
                    next_state = LOAD_IM;
                end
            end
            LOAD_IM: begin
                inc_addr = 1'b1;
                if (tx_done) begin
                    if (im_last) begin
                        next_state = RUN;
                    end else begin
                        im_step    = 1'b1;
                        next_state = WAIT_IM;
                    end
                end
            end
            RUN: begin
                next_state = RUN;           // stays here until reset
            end
            default: next_state = IDLE;
        endcase
    end

    ////////////////////////////////////////
    // counters and word address
    ////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dm_cnt <= '0;
            im_cnt <= '0;
        end else begin
            if (dm_step) dm_cnt <= dm_cnt + 1'b1;
            if (im_step) im_cnt <= im_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            word_addr <= '0;
        end else if (set_addr) begin
            word_addr <= blk_base + 16'(WORD_BYTES);
        end else if (inc_addr) begin
            word_addr <= word_addr + 16'(WORD_BYTES);
        end
    end

    ////////////////////////////////////////
    // outputs
    ////////////////////////////////////////

    assign running = (state == RUN);

    // read request held for the whole block
    always_comb begin
        boot_req             = '0;
        boot_req.op          = HOST_IDLE;
        if (state inside {WAIT_DM, LOAD_DM, WAIT_IM, LOAD_IM}) begin
            boot_req.op          = HOST_READ;
            boot_req.addr.f.zero = '0;
            boot_req.addr.f.inst = in_im;
            boot_req.addr.f.addr = blk_base;
        end
    end

    // core stores only count once running
    always_comb begin
        run_store    = store;
        run_store.en = store.en && running;
    end

    always_comb begin
        dm_wr = '0;
        im_wr = '0;
        if (running) begin
            dm_wr = run_store;
        end else if (in_im) begin
            im_wr = boot_wr;
        end else begin
            dm_wr = boot_wr;                // en low outside the dm burst
        end
    end

endmodule

`default_nettype wire

// File: hdl/cpu_host_mem.sv
// cpu host memory top: boot loader, data and instruction memories, host writer
`timescale 1ns/1ps
`default_nettype none

module cpu_host_mem (
    input  wire                         clk,
    input  wire                         rst_n,
    input  wire                         ready,
    input  wire                         rd_valid,
    input  wire                         tx_done,
    input  wire [31:0]                  ex_wrt_data,
    input  wire cpu_host_pkg::mem_wr_t  store,
    input  wire [15:0]                  ld_addr,
    input  wire [15:0]                  fetch_addr,
    output cpu_host_pkg::host_op_e      op,
    output cpu_host_pkg::host_addr_u    ex_addr,
    output logic [31:0]                 ex_rd_data,
    output logic                        running,
    output logic                        host_busy,
    output logic [31:0]                 ld_data,
    output logic [31:0]                 fetch_instr
);

    import cpu_host_pkg::*;

    host_req_t boot_req;                        // loader read request
    mem_wr_t   dm_wr;
    mem_wr_t   im_wr;
    mem_wr_t   run_store;                       // core store once running

    ////////////////////////////////////////
    // input side
    ////////////////////////////////////////

    boot_loader u_loader (
        .clk        (clk),
        .rst_n      (rst_n),
        .ready      (ready),
        .rd_valid   (rd_valid),
        .tx_done    (tx_done),
        .ex_wrt_data(ex_wrt_data),
        .store      (store),
        .boot_req   (boot_req),
        .dm_wr      (dm_wr),
        .im_wr      (im_wr),
        .run_store  (run_store),
        .running    (running)
    );

    ////////////////////////////////////////
    // memories
    ////////////////////////////////////////

    word_mem #(.DEPTH(DM_DEPTH)) u_dmem (
        .clk    (clk),
        .rst_n  (rst_n),
        .wr     (dm_wr),
        .rd_addr(ld_addr),                  // core load port
        .rd_data(ld_data)
    );

    word_mem #(.DEPTH(IM_DEPTH)) u_imem (
        .clk    (clk),
        .rst_n  (rst_n),
        .wr     (im_wr),
        .rd_addr(fetch_addr),               // instruction fetch port
        .rd_data(fetch_instr)
    );

    ////////////////////////////////////////
    // output side
    ////////////////////////////////////////

    host_writer u_writer (
        .clk       (clk),
        .rst_n     (rst_n),
        .boot_req  (boot_req),
        .run_store (run_store),
        .tx_done   (tx_done),
        .op        (op),
        .ex_addr   (ex_addr),
        .ex_rd_data(ex_rd_data),
        .host_busy (host_busy)
    );

endmodule

`default_nettype wire

// File: hdl/cpu_host_pkg.sv
// cpu host memory package: boot tables, host bus opcode and shared write types
`default_nettype none

package cpu_host_pkg;

    ////////////////////////////////////////
    // sizes and address map
    ////////////////////////////////////////

    localparam int WORD_BYTES = 4;              // byte step between words

    localparam int DM_BLOCKS = 4;
    localparam int IM_BLOCKS = 4;
    localparam int DM_CNT_W  = $clog2(DM_BLOCKS);
    localparam int IM_CNT_W  = $clog2(IM_BLOCKS);

    localparam int DM_DEPTH = 4096;             // words, byte addr bits 13:2
    localparam int IM_DEPTH = 256;              // words, byte addr bits 9:2

    // stores at or above this go out to the host
    localparam logic [15:0] HOST_WIN_BASE = 16'h9000;

    // block bases fetched at boot, in request order
    localparam logic [15:0] DM_BASES [DM_BLOCKS] = '{
        16'h1000,
        16'h1040,
        16'h2000,
        16'h2040
    };

    localparam logic [15:0] IM_BASES [IM_BLOCKS] = '{
        16'h0000,
        16'h0040,
        16'h0080,
        16'h00C0
    };

    ////////////////////////////////////////
    // host bus types
    ////////////////////////////////////////

    typedef enum logic [1:0] {
        HOST_IDLE  = 2'b00,
        HOST_READ  = 2'b01,
        HOST_WRITE = 2'b11
    } host_op_e;

    // word write, shared by boot writes, core stores and memory ports
    typedef struct packed {
        logic [15:0] addr;                      // byte address
        logic [31:0] data;
        logic        en;
    } mem_wr_t;

    typedef struct packed {
        logic [46:0] zero;
        logic        inst;                      // set for instruction space
        logic [15:0] addr;
    } host_addr_fields_t;

    // 64 bit host address, raw or split into fields
    typedef union packed {
        logic [63:0]       raw;
        host_addr_fields_t f;
    } host_addr_u;

    typedef struct packed {
        host_op_e   op;
        host_addr_u addr;
    } host_req_t;

endpackage

`default_nettype wire

// File: hdl/host_writer.sv
// host bus output side: boot read pass-through and held window writes
`timescale 1ns/1ps
`default_nettype none

module host_writer (
    input  wire                          clk,
    input  wire                          rst_n,
    input  wire cpu_host_pkg::host_req_t boot_req,
    input  wire cpu_host_pkg::mem_wr_t   run_store,
    input  wire                          tx_done,
    output cpu_host_pkg::host_op_e       op,
    output cpu_host_pkg::host_addr_u     ex_addr,
    output logic [31:0]                  ex_rd_data,
    output logic                         host_busy
);

    import cpu_host_pkg::*;

    logic        busy;
    logic        win_hit;
    logic [15:0] wr_addr;                       // captured store address
    logic [31:0] wr_data;

    ////////////////////////////////////////
    // window capture
    ////////////////////////////////////////

    assign win_hit = run_store.en && (run_store.addr >= HOST_WIN_BASE);

    // no back-pressure, stores while busy are dropped here
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy <= 1'b0;
        end else if (busy) begin
            if (tx_done) busy <= 1'b0;
        end else if (win_hit) begin
            busy <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!busy && win_hit) begin
            wr_addr <= run_store.addr;
            wr_data <= run_store.data;
        end
    end

    ////////////////////////////////////////
    // bus output select
    ////////////////////////////////////////

    always_comb begin
        op         = boot_req.op;
        ex_addr    = boot_req.addr;
        ex_rd_data = '0;
        if (busy) begin
            op             = HOST_WRITE;
            ex_addr.f.zero = '0;
            ex_addr.f.inst = 1'b0;          // writes go to data space
            ex_addr.f.addr = wr_addr;
            ex_rd_data     = wr_data;
        end
    end

    assign host_busy = busy;

endmodule

`default_nettype wire

// File: hdl/word_mem.sv
// word memory with one write port and a registered read port
`timescale 1ns/1ps
`default_nettype none

module word_mem #(
    parameter int DEPTH = cpu_host_pkg::IM_DEPTH
) (
    input  wire                   clk,
    input  wire                   rst_n,
    input  wire cpu_host_pkg::mem_wr_t wr,
    input  wire [15:0]            rd_addr,
    output logic [31:0]           rd_data
);

    import cpu_host_pkg::*;

    localparam int AW = $clog2(DEPTH);
    localparam int SH = $clog2(WORD_BYTES);      // byte to word shift

    logic [31:0] mem [DEPTH];

    logic [AW-1:0] wr_idx;
    logic [AW-1:0] rd_idx;

    // higher address bits alias onto the same word
    assign wr_idx = wr.addr[SH +: AW];
    assign rd_idx = rd_addr[SH +: AW];

    always_ff @(posedge clk) begin
        if (wr.en) begin
            mem[wr_idx] <= wr.data;
        end
    end

    // one cycle read latency
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_data <= '0;
        end else begin
            rd_data <= mem[rd_idx];
        end
    end

endmodule

`default_nettype wire

// File: tb/host_model.sv
// host model: answers boot reads with block bursts and window writes with tx_done
`timescale 1ns/1ps
`default_nettype none

module host_model #(
    parameter int          BLOCK_WORDS = 16,
    parameter int          MAX_DELAY   = 4,
    parameter logic [31:0] SEED        = 32'h1
) (
    input  wire                           clk,
    input  wire                           rst_n,
    input  wire cpu_host_pkg::host_op_e   op,
    input  wire cpu_host_pkg::host_addr_u ex_addr,
    input  wire [31:0]                    ex_rd_data,
    output logic                          rd_valid,
    output logic                          tx_done,
    output logic [31:0]                   ex_wrt_data,
    output logic [7:0]                    wr_count,
    output logic [15:0]                   wr_addr,
    output logic [31:0]                   wr_data
);

    import cpu_host_pkg::*;

    // address in the upper half, space tag in the lower half
    function automatic logic [31:0] host_word(input logic inst, input logic [15:0] a);
        return {a, inst ? 16'h1000 : 16'hD000};
    endfunction

    task automatic serve_read(input logic inst, input logic [15:0] base);
        int unsigned gap;
        gap = $urandom_range(MAX_DELAY, 1);
        repeat (gap) @(posedge clk);
        rd_valid    <= 1'b1;
        ex_wrt_data <= host_word(inst, base);
        for (int i = 1; i < BLOCK_WORDS; i++) begin
            @(posedge clk);
            rd_valid    <= 1'b0;
            ex_wrt_data <= host_word(inst, base + 16'(i * 4));   // 4 bytes per word
            tx_done     <= (i == BLOCK_WORDS - 1);
        end
        @(posedge clk);
        tx_done <= 1'b0;
    endtask

    task automatic serve_write();
        int unsigned gap;
        wr_count <= wr_count + 8'd1;
        wr_addr  <= ex_addr.f.addr;
        wr_data  <= ex_rd_data;
        gap = $urandom_range(MAX_DELAY, 1);
        repeat (gap) @(posedge clk);
        tx_done <= 1'b1;
        @(posedge clk);
        tx_done <= 1'b0;
    endtask

    initial begin
        void'($urandom(SEED));                  // one seed for all response delays
        rd_valid    <= 1'b0;
        tx_done     <= 1'b0;
        ex_wrt_data <= '0;
        wr_count    <= '0;
        wr_addr     <= '0;
        wr_data     <= '0;
        forever begin
            @(posedge clk);
            if (rst_n && op == HOST_READ) begin
                serve_read(ex_addr.f.inst, ex_addr.f.addr);
            end else if (rst_n && op == HOST_WRITE) begin
                serve_write();
            end
        end
    end

endmodule

`default_nettype wire

// File: tb/tb_cpu_host_mem.sv
// testbench for the cpu host memory: boot load, core ports and window stores
`timescale 1ns/1ps
`default_nettype none

module tb_cpu_host_mem;

    import cpu_host_pkg::*;

    localparam int RESET_CYCLES = 16;
    localparam int BLOCK_WORDS  = 16;
    localparam int MAX_DELAY    = 4;
    localparam int NUM_BLOCKS   = 8;
    localparam int NUM_ROWS     = 19;
    localparam logic [31:0] SEED = 32'h594e1c31;
    // boot bursts, then each row with its worst host delay
    localparam int LIMIT = RESET_CYCLES + NUM_BLOCKS * (BLOCK_WORDS + MAX_DELAY + 4)
                         + NUM_ROWS * (MAX_DELAY + 8) + 50;

    typedef enum logic [2:0] {
        LOAD, FETCH, STORE, WIN_STORE, BUSY_STORE, DRAIN
    } kind_e;

    typedef struct packed {
        kind_e       kind;
        logic [15:0] addr;
        logic [31:0] data;
        logic [31:0] exp;                       // read data, held data or write count
    } row_t;

    localparam logic [63:0] EXP_READS [NUM_BLOCKS] = '{
        64'h0000_0000_0000_1000, 64'h0000_0000_0000_1040,
        64'h0000_0000_0000_2000, 64'h0000_0000_0000_2040,
        64'h0000_0000_0001_0000, 64'h0000_0000_0001_0040,
        64'h0000_0000_0001_0080, 64'h0000_0000_0001_00C0
    };

    localparam row_t ROWS [NUM_ROWS] = '{
        '{LOAD,       16'h1000, 32'h0,         32'h1000_D000},
        '{LOAD,       16'h103C, 32'h0,         32'h103C_D000},
        '{LOAD,       16'h1040, 32'h0,         32'h1040_D000},
        '{LOAD,       16'h107C, 32'h0,         32'h107C_D000},
        '{LOAD,       16'h2000, 32'h0,         32'h2000_D000},
        '{LOAD,       16'h203C, 32'h0,         32'h203C_D000},
        '{LOAD,       16'h2040, 32'h0,         32'h2040_D000},
        '{LOAD,       16'h207C, 32'h0,         32'h207C_D000},
        '{FETCH,      16'h0000, 32'h0,         32'h0000_1000},
        '{FETCH,      16'h0044, 32'h0,         32'h0044_1000},
        '{FETCH,      16'h00BC, 32'h0,         32'h00BC_1000},
        '{FETCH,      16'h00FC, 32'h0,         32'h00FC_1000},
        '{STORE,      16'h3000, 32'hA5A5_0001, 32'h0},
        '{LOAD,       16'h3000, 32'h0,         32'hA5A5_0001},
        '{WIN_STORE,  16'h9004, 32'hC0DE_0001, 32'hC0DE_0001},
        '{BUSY_STORE, 16'h9010, 32'hC0DE_0002, 32'hC0DE_0001},
        '{DRAIN,      16'h9004, 32'hC0DE_0001, 32'h1},
        '{LOAD,       16'h1010, 32'h0,         32'hC0DE_0002},   // dropped store, local alias
        '{LOAD,       16'h1004, 32'h0,         32'hC0DE_0001}
    };

    logic        clk;
    logic        rst_n;
    logic        ready;
    logic        rd_valid;
    logic        tx_done;
    logic [31:0] ex_wrt_data;
    mem_wr_t     store;
    logic [15:0] ld_addr;
    logic [15:0] fetch_addr;
    host_op_e    op;
    host_addr_u  ex_addr;
    logic [31:0] ex_rd_data;
    logic        running;
    logic        host_busy;
    logic [31:0] ld_data;
    logic [31:0] fetch_instr;
    logic [7:0]  wr_count;
    logic [15:0] wr_addr;
    logic [31:0] wr_data;

    logic [63:0] read_log [$];                  // distinct READ requests in order
    logic        run_early;
    logic        was_running;
    logic        tx_seen;
    int          cycles;
    int          n_pass;
    int          n_fail;

    cpu_host_mem u_cpu_host_mem (
        .clk(clk), .rst_n(rst_n), .ready(ready),
        .rd_valid(rd_valid), .tx_done(tx_done), .ex_wrt_data(ex_wrt_data),
        .store(store), .ld_addr(ld_addr), .fetch_addr(fetch_addr),
        .op(op), .ex_addr(ex_addr), .ex_rd_data(ex_rd_data),
        .running(running), .host_busy(host_busy),
        .ld_data(ld_data), .fetch_instr(fetch_instr)
    );

    host_model #(
        .BLOCK_WORDS(BLOCK_WORDS),
        .MAX_DELAY  (MAX_DELAY),
        .SEED       (SEED)
    ) u_host (
        .clk(clk), .rst_n(rst_n), .op(op), .ex_addr(ex_addr),
        .ex_rd_data(ex_rd_data), .rd_valid(rd_valid), .tx_done(tx_done),
        .ex_wrt_data(ex_wrt_data), .wr_count(wr_count),
        .wr_addr(wr_addr), .wr_data(wr_data)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    ////////////////////////////////////////
    // bus monitor and watchdog
    ////////////////////////////////////////

    initial begin
        run_early   = 1'b0;
        was_running = 1'b0;
        tx_seen     = 1'b0;
        forever begin
            @(posedge clk);
            if (op == HOST_READ && (read_log.size() == 0 || read_log[$] != ex_addr.raw)) begin
                read_log.push_back(ex_addr.raw);
            end
            // running must follow the last instruction block's tx_done
            if (running && !was_running) begin
                if (!tx_seen || read_log.size() != NUM_BLOCKS) begin
                    run_early = 1'b1;
                end
            end
            was_running = running;
            tx_seen     = tx_done;
        end
    end

    initial begin
        cycles = 0;
        while (cycles < LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout: run stopped after %0d cycles without finishing", cycles);
        $display("TESTS FAILED");
        $finish;
    end

    ////////////////////////////////////////
    // tests
    ////////////////////////////////////////

    task automatic report_test(input string name, input bit ok);
        if (ok) begin
            n_pass++;
            $display("test %-24s pass", name);
        end else begin
            n_fail++;
            $display("test %-24s FAIL", name);
        end
    endtask

    task automatic log_mismatch(input string what, input logic [31:0] got,
                                input logic [31:0] exp);
        $display("Error at %0t: %s got %h expected %h", $time, what, got, exp);
    endtask

    task automatic run_row(input row_t row, output bit ok);
        logic done_seen;
        ok = 1'b1;
        case (row.kind)
            LOAD: begin
                ld_addr <= row.addr;
                repeat (2) @(posedge clk);  // read registers on the first edge
                if (ld_data !== row.exp) begin
                    log_mismatch("ld_data", ld_data, row.exp);
                    ok = 1'b0;
                end
            end
            FETCH: begin
                fetch_addr <= row.addr;
                repeat (2) @(posedge clk);
                if (fetch_instr !== row.exp) begin
                    log_mismatch("fetch_instr", fetch_instr, row.exp);
                    ok = 1'b0;
                end
            end
            STORE: begin
                store <= '{row.addr, row.data, 1'b1};
                @(posedge clk);
                store.en <= 1'b0;
                @(posedge clk);
                if (host_busy !== 1'b0 || {24'h0, wr_count} !== row.exp) begin
                    log_mismatch("host writes after local store", {24'h0, wr_count}, row.exp);
                    ok = 1'b0;
                end
            end
            WIN_STORE: begin
                store <= '{row.addr, row.data, 1'b1};
                @(posedge clk);
                store.en <= 1'b0;
                @(posedge clk);
                if (op !== HOST_WRITE || host_busy !== 1'b1) begin
                    $display("Error at %0t: op %s busy %b after window store",
                             $time, op.name(), host_busy);
                    ok = 1'b0;
                end
                if (ex_addr.raw !== {48'h0, row.addr}) begin
                    log_mismatch("ex_addr", ex_addr.raw[31:0], {16'h0, row.addr});
                    ok = 1'b0;
                end
                if (ex_rd_data !== row.exp) begin
                    log_mismatch("ex_rd_data", ex_rd_data, row.exp);
                    ok = 1'b0;
                end
            end
            BUSY_STORE: begin
                store <= '{row.addr, row.data, 1'b1};
                @(posedge clk);
                store.en <= 1'b0;
                @(posedge clk);
                // first write still held on the bus
                if (op !== HOST_WRITE || ex_rd_data !== row.exp) begin
                    log_mismatch("held ex_rd_data", ex_rd_data, row.exp);
                    ok = 1'b0;
                end
            end
            DRAIN: begin
                done_seen = 1'b0;
                while (host_busy) begin
                    done_seen = tx_done;        // busy clears on the tx_done edge
                    @(posedge clk);
                end
                if (!done_seen) begin
                    $display("Error at %0t: host_busy did not end right after tx_done",
                             $time);
                    ok = 1'b0;
                end
                @(posedge clk);
                if (op !== HOST_IDLE || {24'h0, wr_count} !== row.exp) begin
                    log_mismatch("host write count", {24'h0, wr_count}, row.exp);
                    ok = 1'b0;
                end
                if (wr_addr !== row.addr || wr_data !== row.data) begin
                    log_mismatch("recorded write data", wr_data, row.data);
                    ok = 1'b0;
                end
            end
            default: ok = 1'b0;
        endcase
    endtask

    initial begin
        bit ok;
        n_pass      = 0;
        n_fail      = 0;
        rst_n      <= 1'b0;
        ready      <= 1'b0;
        store      <= '0;
        ld_addr    <= '0;
        fetch_addr <= '0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);

        ok = 1'b1;
        if (op !== HOST_IDLE || running !== 1'b0 || host_busy !== 1'b0) begin
            $display("Error at %0t: after reset op %s running %b busy %b",
                     $time, op.name(), running, host_busy);
            ok = 1'b0;
        end
        report_test("reset state", ok);

        ready <= 1'b1;
        while (!running) @(posedge clk);
        @(posedge clk);
        ok = !run_early && (read_log.size() == NUM_BLOCKS);
        if (!ok) begin
            $display("Error at %0t: %0d read requests, running rose early %b",
                     $time, read_log.size(), run_early);
        end
        for (int b = 0; b < NUM_BLOCKS && b < read_log.size(); b++) begin
            if (read_log[b] !== EXP_READS[b]) begin
                $display("Error at %0t: read %0d address %h expected %h",
                         $time, b, read_log[b], EXP_READS[b]);
                ok = 1'b0;
            end
        end
        report_test("boot read order", ok);

        for (int r = 0; r < NUM_ROWS; r++) begin
            run_row(ROWS[r], ok);
            report_test($sformatf("%s %h", ROWS[r].kind.name(), ROWS[r].addr), ok);
        end

        $display("%0d tests run, %0d passed, %0d failed", n_pass + n_fail, n_pass, n_fail);
        if (n_fail == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
